// File: Bender.yml
package:
  name: cache_subsystem

sources:
  # RTL
  - include_dirs:
      - source
    files:
      - source/cache_pkg.sv
      - source/cache_way.sv
      - source/cache_lru.sv
      - source/cache_controller.sv
      - source/cache_subsystem.sv
  # Testbench
  - target: simulation
    include_dirs:
      - source
    files:
      - dv/cache_tb_clk.sv
      - dv/cache_tb_mem.sv
      - dv/cache_tb.sv

// File: cache_subsystem.f
+incdir+source
source/cache_pkg.sv
source/cache_way.sv
source/cache_lru.sv
source/cache_controller.sv
source/cache_subsystem.sv
dv/cache_tb_clk.sv
dv/cache_tb_mem.sv
dv/cache_tb.sv

// File: dv/cache_tb.sv
`timescale 1ns/1ps
`default_nettype none

`include "cache_cfg.svh"

module cache_tb;

	typedef logic [`CACHE_ADDR_WIDTH-1:0] addr_t;

	localparam int NUM_SETS = 1 << `CACHE_INDEX_BITS;
	localparam int N_RAND = 48;
	localparam int N_IO = 6;
	// Read-back after the flush is bounded by the number of writes
	localparam int NUM_REQ = 8 + 4 + 2 * N_RAND + 3 + 1 + 3 * N_IO;
	localparam int TIMEOUT_CYCLES = 16 + 20 * NUM_REQ + 10 * NUM_SETS + 200;

	logic clk;
	logic rst_n;
	logic cpu_valid;
	logic cpu_rw;
	logic cpu_flush;
	addr_t cpu_addr;
	cache_pkg::word_t cpu_wdata;
	cache_pkg::word_t cpu_rdata;
	logic cpu_ready;
	logic mem_valid;
	logic mem_rw;
	addr_t mem_addr;
	cache_pkg::block_t mem_wdata;
	cache_pkg::block_t mem_rdata;
	logic mem_ready;
	logic io_valid;
	logic io_rw;
	addr_t io_addr;
	cache_pkg::word_t io_wdata;
	cache_pkg::word_t io_rdata;
	logic io_ready;

	// Shadow model of what the CPU should see
	cache_pkg::word_t shadow [addr_t];
	cache_pkg::word_t io_shadow [addr_t];
	bit line_seen [addr_t];
	addr_t cached_addrs [$];
	integer seed;
	logic started;
	logic expect_hit;
	logic expect_miss;
	cache_pkg::word_t exp_rdata;
	cache_pkg::block_t wb_expect;
	logic saw_fill;
	int flush_cycles;
	int cycle_count = 0;

	cache_tb_clk u_clk (
		.clk   (clk),
		.rst_n (rst_n)
	);

	cache_tb_mem #(.SEED(32'haf27)) u_mem (
		.clk       (clk),
		.rst_n     (rst_n),
		.mem_valid (mem_valid),
		.mem_rw    (mem_rw),
		.mem_addr  (mem_addr),
		.mem_wdata (mem_wdata),
		.mem_rdata (mem_rdata),
		.mem_ready (mem_ready),
		.io_valid  (io_valid),
		.io_rw     (io_rw),
		.io_addr   (io_addr),
		.io_wdata  (io_wdata),
		.io_rdata  (io_rdata),
		.io_ready  (io_ready)
	);

	cache_subsystem uut (
		.clk       (clk),
		.rst_n     (rst_n),
		.cpu_valid (cpu_valid),
		.cpu_rw    (cpu_rw),
		.cpu_flush (cpu_flush),
		.cpu_addr  (cpu_addr),
		.cpu_wdata (cpu_wdata),
		.cpu_rdata (cpu_rdata),
		.cpu_ready (cpu_ready),
		.mem_valid (mem_valid),
		.mem_rw    (mem_rw),
		.mem_addr  (mem_addr),
		.mem_wdata (mem_wdata),
		.mem_rdata (mem_rdata),
		.mem_ready (mem_ready),
		.io_valid  (io_valid),
		.io_rw     (io_rw),
		.io_addr   (io_addr),
		.io_wdata  (io_wdata),
		.io_rdata  (io_rdata),
		.io_ready  (io_ready)
	);

	task automatic report_error(input string msg);
		$display("** Error at %0t: %s", $time, msg);
		$display("Regression failed");
		$fatal(1, "Stopping on the first error");
	endtask

	function automatic addr_t make_addr(input int tag, input int idx, input int off);
		return {cache_pkg::tag_t'(tag), cache_pkg::index_t'(idx), cache_pkg::offset_t'(off)};
	endfunction

	// Written value, or the memory default pattern
	function automatic cache_pkg::word_t shadow_word(input addr_t a);
		return shadow.exists(a) ? shadow[a] : {4'b0, a} ^ 32'h5a5a_0000;
	endfunction

	function automatic cache_pkg::block_t shadow_block(input addr_t base);
		cache_pkg::block_t blk;
		for (int w = 0; w < `CACHE_BLOCK_WORDS; w++)
			blk[w] = shadow_word(base + addr_t'(w));
		return blk;
	endfunction

	function automatic addr_t line_of(input addr_t a);
		return a & ~addr_t'(`CACHE_BLOCK_WORDS - 1);
	endfunction

	function automatic cache_pkg::index_t set_of(input addr_t a);
		return a[`CACHE_OFFSET_BITS +: `CACHE_INDEX_BITS];
	endfunction

	// ------------------------------
	// CPU request driver
	// ------------------------------
	task automatic issue_request(input logic rw, input logic flush, input addr_t addr,
			input cache_pkg::word_t wdata, input cache_pkg::word_t rdata_exp,
			input logic hit, input logic miss);
		cpu_valid = 1'b1;
		cpu_rw = rw;
		cpu_flush = flush;
		cpu_addr = addr;
		cpu_wdata = wdata;
		exp_rdata = rdata_exp;
		expect_hit = hit;
		expect_miss = miss;
		started = 1'b1;
		@(posedge clk);
		while (!cpu_ready)
			@(posedge clk);
		#2;
		cpu_valid = 1'b0;
		cpu_flush = 1'b0;
		expect_hit = 1'b0;
		expect_miss = 1'b0;
		// One idle cycle between requests
		@(posedge clk);
		#2;
	endtask

	task automatic write_word(input addr_t addr, input cache_pkg::word_t data);
		shadow[addr] = data;
		issue_request(1'b1, 1'b0, addr, data, '0, 1'b0, 1'b0);
	endtask

	task automatic read_word(input addr_t addr, input logic hit, input logic miss);
		issue_request(1'b0, 1'b0, addr, '0, shadow_word(addr), hit, miss);
	endtask

	// ------------------------------
	// Monitors
	// ------------------------------
	always @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			saw_fill <= 1'b0;
			flush_cycles <= 0;
		end else if (!cpu_valid) begin
			saw_fill <= 1'b0;
			flush_cycles <= 0;
		end else begin
			if (mem_valid && !mem_rw)
				saw_fill <= 1'b1;
			if (cpu_flush)
				flush_cycles <= flush_cycles + 1;
		end
	end

	// Expected victim line settles well before the next edge
	always @(negedge clk)
		wb_expect = shadow_block(mem_addr);

	always @(posedge clk) begin
		cycle_count <= cycle_count + 1;
		if (cycle_count >= TIMEOUT_CYCLES) begin
			$display("Timeout: no end of test after %0d cycles", cycle_count);
			$display("Regression failed");
			$fatal(1, "Timeout");
		end
	end

	// ------------------------------
	// Checks
	// ------------------------------
	quiet_after_reset: assert property (@(posedge clk) disable iff (!rst_n)
		!started |-> !cpu_ready && !mem_valid && !io_valid)
	else report_error("port active before the first request");

	read_data: assert property (@(posedge clk) disable iff (!rst_n)
		cpu_ready && !cpu_rw && !cpu_flush |-> cpu_rdata == exp_rdata)
	else report_error($sformatf("read of %h returned %h, expected %h",
		$sampled(cpu_addr), $sampled(cpu_rdata), $sampled(exp_rdata)));

	hit_timing: assert property (@(posedge clk) disable iff (!rst_n)
		$rose(cpu_valid) && expect_hit |-> !mem_valid ##1 (cpu_ready && !mem_valid))
	else report_error("hit did not complete in one cycle without memory traffic");

	miss_fill: assert property (@(posedge clk) disable iff (!rst_n)
		cpu_ready && expect_miss |-> saw_fill)
	else report_error($sformatf("read of %h finished without a memory fill",
		$sampled(cpu_addr)));

	write_back_data: assert property (@(posedge clk) disable iff (!rst_n)
		mem_valid && mem_rw && mem_ready |-> mem_wdata == wb_expect)
	else report_error($sformatf("write-back of line %h differs from the shadow",
		$sampled(mem_addr)));

	// Block-aligned, in the set of the request outside a flush, fills for the request line
	mem_addr_check: assert property (@(posedge clk) disable iff (!rst_n)
		mem_valid |-> line_of(mem_addr) == mem_addr
			&& (cpu_flush || set_of(mem_addr) == set_of(cpu_addr))
			&& (mem_rw || mem_addr == line_of(cpu_addr)))
	else report_error($sformatf("memory request to %h does not match the request to %h",
		$sampled(mem_addr), $sampled(cpu_addr)));

	flush_sweep: assert property (@(posedge clk) disable iff (!rst_n)
		cpu_ready && cpu_flush |-> flush_cycles >= 2 * NUM_SETS)
	else report_error("flush finished before sweeping every set");

	flush_single_ready: assert property (@(posedge clk) disable iff (!rst_n)
		cpu_ready && cpu_flush |=> !cpu_ready)
	else report_error("flush returned more than one ready pulse");

	io_no_mem: assert property (@(posedge clk) disable iff (!rst_n)
		io_valid |-> !mem_valid)
	else report_error("memory request during an IO access");

	// IO requests pass straight through with no added cycle
	io_bypass: assert property (@(posedge clk) disable iff (!rst_n)
		io_valid == (cpu_valid && cpu_addr[`CACHE_IO_BIT])
			&& (!io_valid || (io_addr == cpu_addr && io_rw == cpu_rw
				&& io_wdata == cpu_wdata && cpu_ready == io_ready)))
	else report_error("IO port does not follow the CPU request");

	// ------------------------------
	// Stimulus
	// ------------------------------
	initial begin
		addr_t a;
		addr_t line;
		cache_pkg::word_t d;
		int tag_sel;
		int set_sel;
		int off_sel;
		seed = 32'haf27;
		cpu_valid = 1'b0;
		cpu_rw = 1'b0;
		cpu_flush = 1'b0;
		cpu_addr = '0;
		cpu_wdata = '0;
		started = 1'b0;
		expect_hit = 1'b0;
		expect_miss = 1'b0;
		exp_rdata = '0;
		@(posedge rst_n);
		repeat (4) @(posedge clk);
		#2;

		// Cold miss returns the default pattern and the re-read hits
		for (int i = 0; i < 4; i++) begin
			a = make_addr(5, 10 + i, i);
			read_word(a, 1'b0, 1'b1);
			read_word(a, 1'b1, 1'b0);
		end

		// Three tags on set 0 force dirty evictions
		for (int t = 1; t <= 3; t++)
			write_word(make_addr(t, 0, t), $random(seed));
		read_word(make_addr(1, 0, 1), 1'b0, 1'b1);

		for (int n = 0; n < N_RAND; n++) begin
			tag_sel = 1 + $unsigned($random(seed)) % 3;
			set_sel = $unsigned($random(seed)) % 4;
			off_sel = $unsigned($random(seed)) % 8;
			a = make_addr(tag_sel, set_sel, off_sel);
			if ($random(seed) & 1)
				write_word(a, $random(seed));
			else
				read_word(a, 1'b0, 1'b0);
		end

		issue_request(1'b0, 1'b1, '0, '0, '0, 1'b0, 1'b0);

		// After the flush the first touch of every line misses
		if (shadow.first(a)) begin
			do begin
				line = line_of(a);
				read_word(a, 1'b0, !line_seen.exists(line));
				line_seen[line] = 1'b1;
				if (cached_addrs.size() < N_IO)
					cached_addrs.push_back(a);
			end while (shadow.next(a));
		end

		// IO aliases of cached words
		foreach (cached_addrs[k]) begin
			a = cached_addrs[k] | (addr_t'(1) << `CACHE_IO_BIT);
			d = $random(seed);
			io_shadow[a] = d;
			issue_request(1'b1, 1'b0, a, d, '0, 1'b0, 1'b0);
		end
		foreach (cached_addrs[k]) begin
			a = cached_addrs[k] | (addr_t'(1) << `CACHE_IO_BIT);
			issue_request(1'b0, 1'b0, a, '0, io_shadow[a], 1'b0, 1'b0);
		end
		foreach (cached_addrs[k])
			read_word(cached_addrs[k], 1'b0, 1'b0);

		$display("Regression passed");
		$finish;
	end

endmodule

`default_nettype wire

// File: dv/cache_tb_clk.sv
`timescale 1ns/1ps
`default_nettype none

module cache_tb_clk #(
	parameter int PERIOD_NS = 40,
	parameter int RESET_CYCLES = 16
) (
	output logic clk,
	output logic rst_n
);

	initial begin
		clk = 1'b0;
		forever #(PERIOD_NS / 2) clk = ~clk;
	end

	// Release lands just after an edge, like the rest of the stimulus
	initial begin
		rst_n = 1'b0;
		repeat (RESET_CYCLES) @(posedge clk);
		#2;
		rst_n = 1'b1;
	end

endmodule

`default_nettype wire

// File: dv/cache_tb_mem.sv
`timescale 1ns/1ps
`default_nettype none

`include "cache_cfg.svh"

module cache_tb_mem #(
	parameter int SEED = 32'haf27
) (
	input  logic clk,
	input  logic rst_n,

	// Main memory, one line per transfer
	input  logic mem_valid,
	input  logic mem_rw,
	input  logic [`CACHE_ADDR_WIDTH-1:0] mem_addr,
	input  cache_pkg::block_t mem_wdata,
	output cache_pkg::block_t mem_rdata,
	output logic mem_ready,

	// IO device, one word per transfer
	input  logic io_valid,
	input  logic io_rw,
	input  logic [`CACHE_ADDR_WIDTH-1:0] io_addr,
	input  cache_pkg::word_t io_wdata,
	output cache_pkg::word_t io_rdata,
	output logic io_ready
);

	cache_pkg::block_t mem_model [logic [`CACHE_ADDR_WIDTH-1:0]];
	cache_pkg::word_t io_model [logic [`CACHE_ADDR_WIDTH-1:0]];
	integer mem_seed;
	integer io_seed;

	// Unwritten words read as their word address XOR 5a5a0000
	function automatic cache_pkg::block_t read_block(input logic [`CACHE_ADDR_WIDTH-1:0] base);
		cache_pkg::block_t blk;
		if (mem_model.exists(base))
			return mem_model[base];
		for (int w = 0; w < `CACHE_BLOCK_WORDS; w++)
			blk[w] = {4'b0, base + 28'(w)} ^ 32'h5a5a_0000;
		return blk;
	endfunction

	// ------------------------------
	// Main memory responder
	// ------------------------------
	initial begin
		logic [`CACHE_ADDR_WIDTH-1:0] addr;
		int delay;
		mem_seed = SEED;
		mem_ready = 1'b0;
		mem_rdata = '0;
		forever begin
			@(posedge clk);
			if (rst_n && mem_valid) begin
				addr = mem_addr;
				delay = 1 + $unsigned($random(mem_seed)) % 4;
				repeat (delay - 1) @(posedge clk);
				#2;
				if (mem_rw)
					mem_model[addr] = mem_wdata;
				else
					mem_rdata = read_block(addr);
				mem_ready = 1'b1;
				@(posedge clk);
				#2;
				mem_ready = 1'b0;
			end
		end
	end

	// ------------------------------
	// IO device responder
	// ------------------------------
	initial begin
		int delay;
		io_seed = SEED;
		io_ready = 1'b0;
		io_rdata = '0;
		forever begin
			@(posedge clk);
			if (rst_n && io_valid) begin
				delay = 1 + $unsigned($random(io_seed)) % 3;
				repeat (delay - 1) @(posedge clk);
				#2;
				if (io_rw)
					io_model[io_addr] = io_wdata;
				else
					io_rdata = io_model.exists(io_addr) ? io_model[io_addr] : '0;
				io_ready = 1'b1;
				@(posedge clk);
				#2;
				io_ready = 1'b0;
			end
		end
	end

endmodule

`default_nettype wire

// File: source/cache_cfg.svh
`ifndef CACHE_CFG_SVH
`define CACHE_CFG_SVH

// ------------------------------
// Address and data geometry
// ------------------------------

// Word address, laid out as tag, index, offset
`define CACHE_ADDR_WIDTH	28
`define CACHE_WORD_WIDTH	32

// Eight words per line, so a line is 256 bits
`define CACHE_BLOCK_WORDS	8
`define CACHE_OFFSET_BITS	3

// 64 sets per way
`define CACHE_INDEX_BITS	6

// Whatever is left above index and offset
`define CACHE_TAG_BITS	(`CACHE_ADDR_WIDTH - `CACHE_INDEX_BITS - `CACHE_OFFSET_BITS)

// Address bit that sends a request to the IO port
`define CACHE_IO_BIT	27

`endif

// File: source/cache_controller.sv
`timescale 1ns/1ps
`default_nettype none

`include "cache_cfg.svh"

module cache_controller (
	input  logic clk,
	input  logic rst_n,

	// CPU port
	input  logic cpu_valid,
	input  logic cpu_rw,
	input  logic cpu_flush,
	input  logic [`CACHE_ADDR_WIDTH-1:0] cpu_addr,
	input  cache_pkg::word_t cpu_wdata,
	output cache_pkg::word_t cpu_rdata,
	output logic cpu_ready,

	// Memory port
	output logic mem_valid,
	output logic mem_rw,
	output logic [`CACHE_ADDR_WIDTH-1:0] mem_addr,
	output cache_pkg::block_t mem_wdata,
	input  cache_pkg::block_t mem_rdata,
	input  logic mem_ready,

	// IO port
	output logic io_valid,
	output logic io_rw,
	output logic [`CACHE_ADDR_WIDTH-1:0] io_addr,
	output cache_pkg::word_t io_wdata,
	input  cache_pkg::word_t io_rdata,
	input  logic io_ready,

	// Way status
	input  logic [cache_pkg::NUM_WAYS-1:0] way_hit,
	input  logic [cache_pkg::NUM_WAYS-1:0] way_valid,
	input  logic [cache_pkg::NUM_WAYS-1:0] way_dirty,
	input  cache_pkg::tag_t way_tag [cache_pkg::NUM_WAYS],
	input  cache_pkg::block_t way_rblock [cache_pkg::NUM_WAYS],

	// Way control
	output cache_pkg::index_t way_index,
	output cache_pkg::tag_t way_tag_in,
	output logic [cache_pkg::NUM_WAYS-1:0] way_we,
	output cache_pkg::block_t way_wblock,
	output logic way_wdirty,
	output logic [cache_pkg::NUM_WAYS-1:0] way_inval,

	// LRU
	output logic lru_touch,
	output logic lru_way,
	input  logic victim_way
);

	// Flush counter walks set then way, way in the low bit
	localparam int FLUSH_BITS = $bits(cache_pkg::index_t) + 1;

	cache_pkg::ctrl_state_e state;
	cache_pkg::ctrl_state_e state_next;

	logic is_io;
	logic cache_req;
	cache_pkg::tag_t req_tag;
	cache_pkg::index_t req_index;
	cache_pkg::offset_t req_offset;

	logic hit;
	logic hit_way;
	logic sel_way;
	logic sel_dirty;

	logic flushing;
	logic flush_start;
	logic flush_step;
	logic flush_last;
	logic [FLUSH_BITS-1:0] flush_cnt;

	cache_pkg::block_t fill_block;
	cache_pkg::block_t merged_block;
	cache_pkg::word_t cache_rdata;
	logic cache_ready;

	// ------------------------------
	// Request decode
	// ------------------------------
	assign {req_tag, req_index, req_offset} = cpu_addr;

	assign is_io = cpu_addr[`CACHE_IO_BIT];
	assign cache_req = cpu_valid && !is_io;

	// Two ways only, a hit in way 1 selects way 1
	assign hit = |way_hit;
	assign hit_way = way_hit[1];

	// Replacement choice, an empty way goes before the LRU one
	always_comb begin
		if (flushing)
			sel_way = flush_cnt[0];
		else if (!way_valid[0])
			sel_way = 1'b0;
		else if (!way_valid[1])
			sel_way = 1'b1;
		else
			sel_way = victim_way;
	end

	assign sel_dirty = way_valid[sel_way] && way_dirty[sel_way];
	assign flush_last = &flush_cnt;

	assign way_index = flushing ? flush_cnt[FLUSH_BITS-1:1] : req_index;
	assign way_tag_in = req_tag;

	// Hit data path
	assign cache_rdata = way_rblock[hit_way][req_offset];

	always_comb begin
		merged_block = way_rblock[hit_way];
		merged_block[req_offset] = cpu_wdata;
	end

	// ------------------------------
	// Next state and control
	// ------------------------------
	always_comb begin
		state_next = state;
		cache_ready = 1'b0;
		mem_valid = 1'b0;
		mem_rw = 1'b0;
		mem_addr = {req_tag, req_index, cache_pkg::offset_t'(0)};
		way_we = '0;
		way_inval = '0;
		way_wblock = merged_block;
		way_wdirty = 1'b0;
		lru_touch = 1'b0;
		lru_way = hit_way;
		flush_start = 1'b0;
		flush_step = 1'b0;

		case (state)
			cache_pkg::ST_IDLE: begin
				// IO requests never leave idle
				if (cache_req) begin
					if (cpu_flush) begin
						flush_start = 1'b1;
						state_next = cache_pkg::ST_FLUSH;
					end else begin
						state_next = cache_pkg::ST_COMPARE;
					end
				end
			end

			cache_pkg::ST_COMPARE: begin
				if (hit) begin
					cache_ready = 1'b1;
					lru_touch = 1'b1;
					if (cpu_rw) begin
						way_we[hit_way] = 1'b1;
						way_wdirty = 1'b1;
					end
					state_next = cache_pkg::ST_IDLE;
				end else if (sel_dirty) begin
					state_next = cache_pkg::ST_WRITE_BACK;
				end else begin
					state_next = cache_pkg::ST_ALLOCATE;
				end
			end

			cache_pkg::ST_WRITE_BACK: begin
				mem_valid = 1'b1;
				mem_rw = 1'b1;
				mem_addr = {way_tag[sel_way], way_index, cache_pkg::offset_t'(0)};
				if (mem_ready) begin
					if (flushing) begin
						// Line is clean in memory now, drop it and resume the sweep
						way_inval[sel_way] = 1'b1;
						state_next = cache_pkg::ST_FLUSH;
					end else begin
						state_next = cache_pkg::ST_ALLOCATE;
					end
				end
			end

			cache_pkg::ST_ALLOCATE: begin
				mem_valid = 1'b1;
				if (mem_ready)
					state_next = cache_pkg::ST_FILL;
			end

			cache_pkg::ST_FILL: begin
				way_we[sel_way] = 1'b1;
				way_wblock = fill_block;
				lru_touch = 1'b1;
				lru_way = sel_way;
				state_next = cache_pkg::ST_COMPARE;
			end

			cache_pkg::ST_FLUSH: begin
				if (sel_dirty) begin
					state_next = cache_pkg::ST_WRITE_BACK;
				end else begin
					way_inval[sel_way] = 1'b1;
					flush_step = 1'b1;
					if (flush_last) begin
						cache_ready = 1'b1;
						state_next = cache_pkg::ST_IDLE;
					end
				end
			end

			default: state_next = cache_pkg::ST_IDLE;
		endcase
	end

	// ------------------------------
	// State and flush sweep
	// ------------------------------
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			state <= cache_pkg::ST_IDLE;
			flushing <= 1'b0;
			flush_cnt <= '0;
		end else begin
			state <= state_next;
			if (flush_start) begin
				flushing <= 1'b1;
				flush_cnt <= '0;
			end else if (flush_step) begin
				flush_cnt <= flush_cnt + 1'b1;
				if (flush_last)
					flushing <= 1'b0;
			end
		end
	end

	// Block from memory is written into the way one cycle later
	always_ff @(posedge clk) begin
		if (state == cache_pkg::ST_ALLOCATE && mem_ready)
			fill_block <= mem_rdata;
	end

	// Victim line goes out on the memory port during write-back
	assign mem_wdata = way_rblock[sel_way];

	// ------------------------------
	// IO bypass and CPU return path
	// ------------------------------
	assign io_valid = cpu_valid && is_io;
	assign io_rw = cpu_rw && is_io;
	assign io_addr = cpu_addr;
	assign io_wdata = cpu_wdata;

	assign cpu_ready = is_io ? io_ready : cache_ready;
	assign cpu_rdata = is_io ? io_rdata : cache_rdata;

endmodule

`default_nettype wire

// File: source/cache_lru.sv
`timescale 1ns/1ps
`default_nettype none

module cache_lru (
	input  logic clk,
	input  logic rst_n,

	input  cache_pkg::index_t index,
	input  logic touch,
	input  logic touch_way,

	// Least recently used way of the set at index
	output logic victim_way
);

	localparam int NUM_SETS = 2 ** $bits(cache_pkg::index_t);

	// One bit per set naming the LRU way
	logic [NUM_SETS-1:0] lru_bits;

	// ------------------------------
	// Update on hits and fills
	// ------------------------------
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			lru_bits <= '0;
		end else if (touch) begin
			// Touched way becomes most recent, the other one is next out
			lru_bits[index] <= ~touch_way;
		end
	end

	assign victim_way = lru_bits[index];

endmodule

`default_nettype wire

// File: source/cache_pkg.sv
`default_nettype none

`include "cache_cfg.svh"

package cache_pkg;

	// Way count is fixed, the LRU is a single bit per set
	localparam int NUM_WAYS = 2;

	// ------------------------------
	// Data and address fields
	// ------------------------------
	typedef logic [`CACHE_WORD_WIDTH-1:0] word_t;
	typedef word_t [`CACHE_BLOCK_WORDS-1:0] block_t;

	typedef logic [`CACHE_TAG_BITS-1:0] tag_t;
	typedef logic [`CACHE_INDEX_BITS-1:0] index_t;
	typedef logic [`CACHE_OFFSET_BITS-1:0] offset_t;

	// Controller states
	typedef enum logic [2:0] {
		ST_IDLE,
		ST_COMPARE,
		ST_WRITE_BACK,
		ST_ALLOCATE,
		ST_FILL,
		ST_FLUSH
	} ctrl_state_e;

endpackage

`default_nettype wire

// File: source/cache_subsystem.sv
`timescale 1ns/1ps
`default_nettype none

`include "cache_cfg.svh"

module cache_subsystem (
	input  logic clk,
	input  logic rst_n,

	// CPU port
	input  logic cpu_valid,
	input  logic cpu_rw,
	input  logic cpu_flush,
	input  logic [`CACHE_ADDR_WIDTH-1:0] cpu_addr,
	input  logic [`CACHE_WORD_WIDTH-1:0] cpu_wdata,
	output logic [`CACHE_WORD_WIDTH-1:0] cpu_rdata,
	output logic cpu_ready,

	// Memory port, one line per transfer
	output logic mem_valid,
	output logic mem_rw,
	output logic [`CACHE_ADDR_WIDTH-1:0] mem_addr,
	output cache_pkg::block_t mem_wdata,
	input  cache_pkg::block_t mem_rdata,
	input  logic mem_ready,

	// IO port
	output logic io_valid,
	output logic io_rw,
	output logic [`CACHE_ADDR_WIDTH-1:0] io_addr,
	output logic [`CACHE_WORD_WIDTH-1:0] io_wdata,
	input  logic [`CACHE_WORD_WIDTH-1:0] io_rdata,
	input  logic io_ready
);

	logic [cache_pkg::NUM_WAYS-1:0] way_hit;
	logic [cache_pkg::NUM_WAYS-1:0] way_valid;
	logic [cache_pkg::NUM_WAYS-1:0] way_dirty;
	cache_pkg::tag_t way_tag [cache_pkg::NUM_WAYS];
	cache_pkg::block_t way_rblock [cache_pkg::NUM_WAYS];

	cache_pkg::index_t way_index;
	cache_pkg::tag_t way_tag_in;
	logic [cache_pkg::NUM_WAYS-1:0] way_we;
	cache_pkg::block_t way_wblock;
	logic way_wdirty;
	logic [cache_pkg::NUM_WAYS-1:0] way_inval;

	logic lru_touch;
	logic lru_way;
	logic victim_way;

	// ------------------------------
	// Storage ways
	// ------------------------------
	for (genvar g = 0; g < cache_pkg::NUM_WAYS; g++) begin : g_way
		cache_way u_way (
			.clk        (clk),
			.rst_n      (rst_n),
			.index      (way_index),
			.tag        (way_tag_in),
			.write_en   (way_we[g]),
			.wblock     (way_wblock),
			.wdirty     (way_wdirty),
			.invalidate (way_inval[g]),
			.hit        (way_hit[g]),
			.valid      (way_valid[g]),
			.dirty      (way_dirty[g]),
			.stored_tag (way_tag[g]),
			.rblock     (way_rblock[g])
		);
	end

	cache_lru u_lru (
		.clk        (clk),
		.rst_n      (rst_n),
		.index      (way_index),
		.touch      (lru_touch),
		.touch_way  (lru_way),
		.victim_way (victim_way)
	);

	// Controller
	cache_controller u_ctrl (
		.clk        (clk),
		.rst_n      (rst_n),
		.cpu_valid  (cpu_valid),
		.cpu_rw     (cpu_rw),
		.cpu_flush  (cpu_flush),
		.cpu_addr   (cpu_addr),
		.cpu_wdata  (cpu_wdata),
		.cpu_rdata  (cpu_rdata),
		.cpu_ready  (cpu_ready),
		.mem_valid  (mem_valid),
		.mem_rw     (mem_rw),
		.mem_addr   (mem_addr),
		.mem_wdata  (mem_wdata),
		.mem_rdata  (mem_rdata),
		.mem_ready  (mem_ready),
		.io_valid   (io_valid),
		.io_rw      (io_rw),
		.io_addr    (io_addr),
		.io_wdata   (io_wdata),
		.io_rdata   (io_rdata),
		.io_ready   (io_ready),
		.way_hit    (way_hit),
		.way_valid  (way_valid),
		.way_dirty  (way_dirty),
		.way_tag    (way_tag),
		.way_rblock (way_rblock),
		.way_index  (way_index),
		.way_tag_in (way_tag_in),
		.way_we     (way_we),
		.way_wblock (way_wblock),
		.way_wdirty (way_wdirty),
		.way_inval  (way_inval),
		.lru_touch  (lru_touch),
		.lru_way    (lru_way),
		.victim_way (victim_way)
	);

endmodule

`default_nettype wire

// File: source/cache_way.sv
`timescale 1ns/1ps
`default_nettype none

module cache_way (
	input  logic clk,
	input  logic rst_n,

	// Lookup and update
	input  cache_pkg::index_t index,
	input  cache_pkg::tag_t tag,
	input  logic write_en,
	input  cache_pkg::block_t wblock,
	input  logic wdirty,
	input  logic invalidate,

	// Line state at index
	output logic hit,
	output logic valid,
	output logic dirty,
	output cache_pkg::tag_t stored_tag,
	output cache_pkg::block_t rblock
);

	localparam int NUM_SETS = 2 ** $bits(cache_pkg::index_t);

	cache_pkg::tag_t tag_mem [NUM_SETS];
	cache_pkg::block_t data_mem [NUM_SETS];
	logic [NUM_SETS-1:0] valid_bits;
	logic [NUM_SETS-1:0] dirty_bits;

	// ------------------------------
	// Line status bits
	// ------------------------------
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			valid_bits <= '0;
			dirty_bits <= '0;
		end else if (write_en) begin
			valid_bits[index] <= 1'b1;
			dirty_bits[index] <= wdirty;
		end else if (invalidate) begin
			valid_bits[index] <= 1'b0;
			dirty_bits[index] <= 1'b0;
		end
	end

	// Tag and data storage
	always_ff @(posedge clk) begin
		if (write_en) begin
			tag_mem[index] <= tag;
			data_mem[index] <= wblock;
		end
	end

	// ------------------------------
	// Combinational read port
	// ------------------------------
	assign valid = valid_bits[index];
	assign dirty = dirty_bits[index];
	assign stored_tag = tag_mem[index];
	assign rblock = data_mem[index];

	// Hit only when the line holds data for this tag
	assign hit = valid && (stored_tag == tag);

endmodule

`default_nettype wire
